/* cpu.f */
hw/cpuPkg.sv
hw/fetchUnit.sv
hw/decode.sv
hw/regFile.sv
hw/alu.sv
hw/dataMem.sv
hw/cpu.sv
tb/clockGen.sv
tb/cpuTb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - hw/cpuPkg.sv
  - hw/fetchUnit.sv
  - hw/decode.sv
  - hw/regFile.sv
  - hw/alu.sv
  - hw/dataMem.sv
  - hw/cpu.sv
  - target: simulation
    files:
      - tb/clockGen.sv
      - tb/cpuTb.sv

/* tb/programInput.txt */
# L imemAdrx word | W reg value (register write) | S byteAdrx data (store) | F finalPc
# Columns are hex, expected events are listed in commit order
L 000 2001000a
L 001 2002fffd
L 002 00221820
L 003 00222022
L 004 00222824
L 005 00223025
L 006 00223826
L 007 0041402a
L 008 0022482a
L 009 00015100
L 00a ac030008
L 00b 8c0b0008
L 00c 20200005
L 00d fc000000
L 00e 00006020
L 00f 1c220011
L 010 200d0063
L 011 1c410010
L 012 1c210010
L 013 200e0016
L 014 01c00008
L 015 200f0001
L 016 08000018
L 017 20100001
L 018 20100055
L 019 08000019
W 01 0000000a
W 02 fffffffd
W 03 00000007
W 04 0000000d
W 05 00000008
W 06 ffffffff
W 07 fffffff7
W 08 00000001
W 09 00000000
W 0a 000000a0
S 00000008 00000007
W 0b 00000007
W 0c 00000000
W 0e 00000016
W 10 00000055
F 019

/* tb/cpuTb.sv */
/*
 * cpuTb: loads a program into the core, runs it in random phases with halted gaps
 * and compares the register write and store trace with the expected trace
 */
module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	localparam int timeoutCycles = 2000;

	logic clk;
	logic rst;
	logic run;
	logic loadEn;
	logic [pcWidth-1:0] loadAdrx;
	logic [dataWidth-1:0] loadData;
	logic [pcWidth-1:0] pc;
	logic wbEn;
	logic [regAdrxWidth-1:0] wbAdrx;
	logic [dataWidth-1:0] wbData;
	logic memWe;
	logic [dataWidth-1:0] memAdrx;
	logic [dataWidth-1:0] memData;

	// Program image and expected trace
	logic [dataWidth-1:0] progAdrx[$];
	logic [dataWidth-1:0] progWord[$];
	byte expKind[$];
	logic [dataWidth-1:0] expA[$];
	logic [dataWidth-1:0] expB[$];
	logic [dataWidth-1:0] finalPc;
	int evIdx = 0;
	int checks = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	int seed;
	int idleCycles;
	bit ok;

	clockGen i_clockGen (.clk(clk), .rst(rst));

	cpu i_cpu (
		.clk(clk), .rst(rst), .run(run),
		.loadEn(loadEn), .loadAdrx(loadAdrx), .loadData(loadData),
		.pc(pc), .wbEn(wbEn), .wbAdrx(wbAdrx), .wbData(wbData),
		.memWe(memWe), .memAdrx(memAdrx), .memData(memData)
	);

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic readInput(output bit done);
		int fd;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("tb/programInput.txt", "r");
		done = (fd != 0);
		if (!done) begin
			$display("Could not open the program input file");
			otherErrors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 3 || line[0] == "#") begin
				continue;
			end
			void'($sscanf(line.substr(2, line.len() - 1), "%h %h", a, b));
			case (line[0])
				"L": begin
					progAdrx.push_back(a);
					progWord.push_back(b);
				end
				"F": finalPc = a;
				default: begin
					expKind.push_back(line[0]);
					expA.push_back(a);
					expB.push_back(b);
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic waitReset(output bit done);
		int cycles;
		cycles = 0;
		while (rst && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		done = !rst;
		if (!done) begin
			$display("Timed out waiting for reset to be released");
			otherErrors++;
		end
	endtask

	// While halted nothing may commit and the PC must hold
	task automatic checkHalted(input logic [31:0] heldPc);
		checkValue("pc", pc, heldPc);
		checkValue("wbEn", wbEn, 1'b0);
		checkValue("memWe", memWe, 1'b0);
	endtask

	task automatic loadProgram();
		foreach (progAdrx[i]) begin
			@(negedge clk);
			checkHalted('0);
			loadEn = 1'b1;
			loadAdrx = progAdrx[i][pcWidth-1:0];
			loadData = progWord[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
	endtask

	task automatic runProgram(output bit done);
		int cycles;
		int phase;
		int gap;
		logic [31:0] heldPc;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < timeoutCycles) begin
			phase = 2 + $urandom % 7;
			gap = 1 + $urandom % 4;
			run = 1'b1;
			for (int i = 0; i < phase && !done; i++) begin
				@(negedge clk);
				cycles++;
				done = (evIdx >= expKind.size()) && (pc == finalPc[pcWidth-1:0]);
			end
			run = 1'b0;
			heldPc = pc;
			for (int i = 0; i < gap; i++) begin
				@(negedge clk);
				cycles++;
				checkHalted(heldPc);
			end
		end
		if (!done) begin
			$display("Timed out after %0d cycles waiting for the program to finish", cycles);
			otherErrors++;
		end
	endtask

	task automatic matchEvent(input byte kind, input logic [31:0] a, input logic [31:0] d,
			input string aName, input string dName);
		assert (evIdx < expKind.size()) else begin
			$display("Unexpected %c event after the end of the expected trace", kind);
			otherErrors++;
		end
		if (evIdx < expKind.size()) begin
			assert (expKind[evIdx] == kind) else begin
				$display("Event %0d should be %c but %c was seen", evIdx, expKind[evIdx], kind);
				otherErrors++;
			end
			checkValue(aName, a, expA[evIdx]);
			checkValue(dName, d, expB[evIdx]);
			evIdx++;
		end
	endtask

	// Events are visible the cycle before the edge that commits them
	always @(posedge clk) begin
		if (!rst && run) begin
			if (wbEn) begin
				matchEvent("W", wbAdrx, wbData, "wbAdrx", "wbData");
			end
			if (memWe) begin
				matchEvent("S", memAdrx, memData, "memAdrx", "memData");
			end
		end
	end

	initial begin
		run = 1'b0;
		loadEn = 1'b0;
		loadAdrx = '0;
		loadData = '0;
		finalPc = '0;
		seed = 44;
		void'($urandom(seed));
		readInput(ok);
		if (ok) begin
			waitReset(ok);
		end
		if (ok) begin
			idleCycles = 1 + $urandom % 5;
			for (int i = 0; i < idleCycles; i++) begin
				@(negedge clk);
				checkHalted('0);
			end
			loadProgram();
			runProgram(ok);
		end
		if (ok) begin
			// Self-jump, the PC stays put and nothing more commits
			run = 1'b1;
			repeat (4) @(negedge clk);
			run = 1'b0;
			checkValue("pc", pc, finalPc);
			assert (evIdx == expKind.size()) else begin
				$display("Only %0d of %0d expected events were seen", evIdx, expKind.size());
				otherErrors++;
			end
		end
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* tb/clockGen.sv */
/*
 * clockGen: 10 ns testbench clock and a 16-cycle synchronous reset
 */
module clockGen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 16;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* hw/cpu.sv */
/*
 * cpu: single-cycle core top, fetch, decode, register file, ALU and data memory.
 * Register writes and stores are exposed as the events about to commit.
 */
module cpu (
	input logic clk,
	input logic rst,
	input logic run,
	input logic loadEn,
	input logic [cpuPkg::pcWidth-1:0] loadAdrx,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic wbEn,
	output logic [cpuPkg::regAdrxWidth-1:0] wbAdrx,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic memWe,
	output logic [cpuPkg::dataWidth-1:0] memAdrx,
	output logic [cpuPkg::dataWidth-1:0] memData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] instruction;
	logic [regAdrxWidth-1:0] rdAdrx0;
	logic [regAdrxWidth-1:0] rdAdrx1;
	logic [immWidth-1:0] immediate;
	aluOpT aluOp;
	logic aluBusBSel;
	logic resultSel;
	logic rfWriteEn;
	logic dmemRead;
	logic dmemWrite;
	pcSelT pcSel;
	logic [pcWidth-1:0] target;
	logic [dataWidth-1:0] rdData0;
	logic [dataWidth-1:0] rdData1;
	logic [dataWidth-1:0] busB;
	logic [dataWidth-1:0] aluResult;
	logic negFlag;
	logic zeroFlag;

	fetchUnit i_fetchUnit (
		.clk(clk), .rst(rst), .run(run),
		.loadEn(loadEn), .loadAdrx(loadAdrx), .loadData(loadData),
		.pcSel(pcSel), .target(target), .regTarget(rdData0[pcWidth-1:0]),
		.pc(pc), .instruction(instruction)
	);

	decode i_decode (
		.instruction(instruction), .negFlag(negFlag), .zeroFlag(zeroFlag),
		.rdAdrx0(rdAdrx0), .rdAdrx1(rdAdrx1), .wrAdrx(wbAdrx),
		.immediate(immediate), .aluOp(aluOp), .aluBusBSel(aluBusBSel),
		.resultSel(resultSel), .rfWriteEn(rfWriteEn), .dmemRead(dmemRead),
		.dmemWrite(dmemWrite), .pcSel(pcSel), .target(target)
	);

	// Nothing commits while halted
	assign wbEn = rfWriteEn && run;
	assign memWe = dmemWrite && run;

	regFile i_regFile (
		.clk(clk), .rst(rst), .writeEn(wbEn), .wrAdrx(wbAdrx), .wrData(wbData),
		.rdAdrx0(rdAdrx0), .rdAdrx1(rdAdrx1), .rdData0(rdData0), .rdData1(rdData1)
	);

	// Sign-extended immediate or second register operand
	assign busB = (aluBusBSel == busBImm) ? {{16{immediate[immWidth-1]}}, immediate} : rdData1;

	alu i_alu (
		.aluOp(aluOp), .busA(rdData0), .busB(busB),
		.result(aluResult), .negFlag(negFlag), .zeroFlag(zeroFlag)
	);

	dataMem i_dataMem (
		.clk(clk), .rst(rst), .dmemRead(dmemRead), .dmemWrite(memWe),
		.adrx(aluResult), .wrData(rdData1), .aluResult(aluResult),
		.resultSel(resultSel), .wbData(wbData)
	);

	assign memAdrx = aluResult;
	assign memData = rdData1;

endmodule

/* hw/dataMem.sv */
/*
 * dataMem: 256-word data memory and the writeback select between ALU and memory
 */
module dataMem (
	input logic clk,
	input logic rst,
	input logic dmemRead,
	input logic dmemWrite,
	input logic [cpuPkg::dataWidth-1:0] adrx,
	input logic [cpuPkg::dataWidth-1:0] wrData,
	input logic [cpuPkg::dataWidth-1:0] aluResult,
	input logic resultSel,
	output logic [cpuPkg::dataWidth-1:0] wbData
);
	import cpuPkg::*;

	localparam int dmemWords = 1 << dmemAdrxWidth;

	logic [dataWidth-1:0] mem [dmemWords];
	logic [dmemAdrxWidth-1:0] wordAdrx;
	logic [dataWidth-1:0] rdData;

	// Byte address to word index
	assign wordAdrx = adrx[dmemAdrxWidth+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dmemWords; i++) begin
				mem[i] <= '0;
			end
		end else if (dmemWrite) begin
			mem[wordAdrx] <= wrData;
		end
	end

	assign rdData = dmemRead ? mem[wordAdrx] : '0;
	assign wbData = (resultSel == resultMem) ? rdData : aluResult;

	// Only whole words are accessed, there is no byte access
	wordAligned: assert property (@(posedge clk) disable iff (rst)
		(dmemRead || dmemWrite) |-> (adrx[1:0] == 2'b00))
		else $error("dataMem: unaligned word access");

endmodule

/* hw/alu.sv */
/*
 * alu: eight-operation integer ALU with negative and zero flags
 */
module alu (
	input cpuPkg::aluOpT aluOp,
	input logic [cpuPkg::dataWidth-1:0] busA,
	input logic [cpuPkg::dataWidth-1:0] busB,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic negFlag,
	output logic zeroFlag
);
	import cpuPkg::*;

	logic [4:0] shamt;

	assign shamt = busB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd: result = busA + busB;
			aluSub: result = busA - busB;
			aluAnd: result = busA & busB;
			aluOr: result = busA | busB;
			aluXor: result = busA ^ busB;
			aluSlt: begin
				// Signed compare, result is 1 or 0
				result = ($signed(busA) < $signed(busB)) ? 32'd1 : 32'd0;
			end
			aluSll: result = busA << shamt;
			default: result = '0;
		endcase
	end

	// Flags follow the result, overflow is not tracked
	assign negFlag = result[dataWidth-1];
	assign zeroFlag = (result == '0);

endmodule

/* hw/regFile.sv */
/*
 * regFile: 32 x 32 register file, two asynchronous reads, one synchronous write
 */
module regFile (
	input logic clk,
	input logic rst,
	input logic writeEn,
	input logic [cpuPkg::regAdrxWidth-1:0] wrAdrx,
	input logic [cpuPkg::dataWidth-1:0] wrData,
	input logic [cpuPkg::regAdrxWidth-1:0] rdAdrx0,
	input logic [cpuPkg::regAdrxWidth-1:0] rdAdrx1,
	output logic [cpuPkg::dataWidth-1:0] rdData0,
	output logic [cpuPkg::dataWidth-1:0] rdData1
);
	import cpuPkg::*;

	localparam int numRegs = 1 << regAdrxWidth;

	logic [dataWidth-1:0] regs [numRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (wrAdrx != '0)) begin
			regs[wrAdrx] <= wrData;
		end
	end

	// Register 0 is hardwired to zero
	assign rdData0 = (rdAdrx0 == '0) ? '0 : regs[rdAdrx0];
	assign rdData1 = (rdAdrx1 == '0) ? '0 : regs[rdAdrx1];

endmodule

/* hw/decode.sv */
/*
 * decode: turns an instruction word into control levels, register fields,
 * the immediate and the next-PC select for j, jr and bgt
 */
module decode (
	input logic [cpuPkg::dataWidth-1:0] instruction,
	input logic negFlag,
	input logic zeroFlag,
	output logic [cpuPkg::regAdrxWidth-1:0] rdAdrx0,
	output logic [cpuPkg::regAdrxWidth-1:0] rdAdrx1,
	output logic [cpuPkg::regAdrxWidth-1:0] wrAdrx,
	output logic [cpuPkg::immWidth-1:0] immediate,
	output cpuPkg::aluOpT aluOp,
	output logic aluBusBSel,
	output logic resultSel,
	output logic rfWriteEn,
	output logic dmemRead,
	output logic dmemWrite,
	output cpuPkg::pcSelT pcSel,
	output logic [cpuPkg::pcWidth-1:0] target
);
	import cpuPkg::*;

	opcodeT opcode;
	functT funct;
	logic [regAdrxWidth-1:0] rs;
	logic [regAdrxWidth-1:0] rt;
	logic [regAdrxWidth-1:0] rd;
	logic writeReg;
	logic rdDest;
	logic shiftOp;
	logic jump;
	logic jumpReg;
	logic branch;

	assign opcode = opcodeT'(instruction[31:26]);
	assign funct = functT'(instruction[5:0]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];

	always_comb begin
		aluOp = aluNop;
		aluBusBSel = busBReg;
		resultSel = resultAlu;
		writeReg = 1'b0;
		rdDest = 1'b0;
		shiftOp = 1'b0;
		dmemRead = 1'b0;
		dmemWrite = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		branch = 1'b0;
		case (opcode)
			opReg: begin
				rdDest = 1'b1;
				writeReg = 1'b1;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnSlt: aluOp = aluSlt;
					fnSll: begin
						// rt shifted by shamt, carried on bus B
						aluOp = aluSll;
						aluBusBSel = busBImm;
						shiftOp = 1'b1;
					end
					fnJr: begin
						writeReg = 1'b0;
						jumpReg = 1'b1;
					end
					default: writeReg = 1'b0;
				endcase
			end
			opLw: begin
				aluOp = aluAdd;
				aluBusBSel = busBImm;
				resultSel = resultMem;
				writeReg = 1'b1;
				dmemRead = 1'b1;
			end
			opSw: begin
				aluOp = aluAdd;
				aluBusBSel = busBImm;
				dmemWrite = 1'b1;
			end
			opJ: jump = 1'b1;
			opBgt: begin
				// rs - rt, taken when the difference is positive
				aluOp = aluSub;
				branch = 1'b1;
			end
			opAddi: begin
				aluOp = aluAdd;
				aluBusBSel = busBImm;
				writeReg = 1'b1;
			end
			default: ;
		endcase
	end

	assign rdAdrx0 = shiftOp ? rt : rs;
	assign rdAdrx1 = rt;
	assign wrAdrx = rdDest ? rd : rt;
	assign rfWriteEn = writeReg && (wrAdrx != '0);
	assign immediate = shiftOp ? {11'b0, instruction[10:6]} : instruction[immWidth-1:0];

	// j and bgt both take the low bits of the word
	assign target = instruction[pcWidth-1:0];

	always_comb begin
		if (jumpReg) begin
			pcSel = pcRegister;
		end else if (jump || (branch && !negFlag && !zeroFlag)) begin
			pcSel = pcTarget;
		end else begin
			pcSel = pcNext;
		end
	end

endmodule

/* hw/fetchUnit.sv */
/*
 * fetchUnit: program counter, next-PC select and instruction memory.
 * The memory is loaded from outside while the core is halted.
 */
module fetchUnit (
	input logic clk,
	input logic rst,
	input logic run,
	input logic loadEn,
	input logic [cpuPkg::pcWidth-1:0] loadAdrx,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	input cpuPkg::pcSelT pcSel,
	input logic [cpuPkg::pcWidth-1:0] target,
	input logic [cpuPkg::pcWidth-1:0] regTarget,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] instruction
);
	import cpuPkg::*;

	localparam int instrWords = 1 << pcWidth;

	logic [dataWidth-1:0] imem [instrWords];
	logic [pcWidth-1:0] nextPc;

	always_comb begin
		case (pcSel)
			pcTarget: nextPc = target;
			pcRegister: nextPc = regTarget;
			default: nextPc = pc + 1'b1;
		endcase
	end

	// PC only moves while the core runs
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (run) begin
			pc <= nextPc;
		end
	end

	// Load port, only honoured while halted
	always_ff @(posedge clk) begin
		if (loadEn && !run) begin
			imem[loadAdrx] <= loadData;
		end
	end

	assign instruction = imem[pc];

	// Program loading and execution never overlap
	loadWhileRun: assert property (@(posedge clk) disable iff (rst) !(loadEn && run))
		else $error("fetchUnit: instruction load attempted while running");

endmodule

/* hw/cpuPkg.sv */
/*
 * cpuPkg: shared sizes, encodings and control enums for the single-cycle core
 */
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAdrxWidth = 5;
	localparam int pcWidth = 9;
	localparam int dmemAdrxWidth = 8;
	localparam int immWidth = 16;

	// ALU bus B source
	localparam logic busBReg = 1'b0;
	localparam logic busBImm = 1'b1;

	// Writeback source
	localparam logic resultAlu = 1'b0;
	localparam logic resultMem = 1'b1;

	// Primary opcodes, bgt is our own encoding
	typedef enum logic [5:0] {
		opReg = 6'b000000,
		opJ = 6'b000010,
		opBgt = 6'b000111,
		opAddi = 6'b001000,
		opLw = 6'b100011,
		opSw = 6'b101011
	} opcodeT;

	// Function field of register-type words
	typedef enum logic [5:0] {
		fnSll = 6'b000000,
		fnJr = 6'b001000,
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr = 6'b100101,
		fnXor = 6'b100110,
		fnSlt = 6'b101010
	} functT;

	typedef enum logic [2:0] {
		aluNop = 3'b000,
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluOr = 3'b100,
		aluXor = 3'b101,
		aluSlt = 3'b110,
		aluSll = 3'b111
	} aluOpT;

	// Where the next PC comes from
	typedef enum logic [1:0] {
		pcNext = 2'b00,
		pcTarget = 2'b01,
		pcRegister = 2'b10
	} pcSelT;

endpackage
